/* common/dma_init_defines.svh */
`ifndef DMA_INIT_DEFINES_SVH
`define DMA_INIT_DEFINES_SVH

// Bus and AXI widths
`define DATA_W     32
`define ADDR_W     32
`define NUM_REGS   32
`define REG_IDX_W  5
`define BUF_IDX_W  5
`define NUM_CMDS   3'd6

// Register indices
// MSB of the CE vector selects index 0
`define REG_LEN      5'd0
`define REG_BUF      5'd1
`define REG_FRAMES   5'd2
`define REG_CMD_IDX  5'd3

// Frame window for each buffer, 4 MiB
`define WINDOW_BYTES 32'h0040_0000

// DMA register map
`define DMA_CTRL_ADDR 32'h7900_000C
`define DMA_CFG0_ADDR 32'h4040_0030
`define DMA_CFG1_ADDR 32'h4040_0034
`define DMA_DEST_ADDR 32'h4040_0048
`define DMA_LEN_ADDR  32'h4040_0058

// Command data
`define DMA_CFG0_DATA 32'h0000_1001
`define DMA_CFG1_DATA 32'h0000_1000
`define DMA_LEN_DATA  32'hFFFF_FFFF
`define DMA_START_BIT 32'h0001_0000

`endif

/* common/dma_init_pkg.sv */
`include "dma_init_defines.svh"

package dma_init_pkg;

  typedef logic [`DATA_W-1:0]    data_t;
  typedef logic [`ADDR_W-1:0]    addr_t;
  typedef logic [`REG_IDX_W-1:0] reg_idx_t;
  typedef logic [`BUF_IDX_W-1:0] buf_idx_t;
  typedef logic [2:0]            cmd_idx_t;

  // Processor request after the first register stage
  typedef struct packed {
    logic     sel;
    logic     rwn;
    reg_idx_t idx;
    data_t    wdata;
  } up_req_t;

  // One AXI4-Lite write
  typedef struct packed {
    addr_t addr;
    data_t data;
  } axil_wr_cmd_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ISSUE,
    SEQ_WAIT,
    SEQ_DONE
  } seq_state_t;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_ADDR_DATA,
    WR_RESP
  } wr_state_t;

endpackage

/* hw/dma_init_top.sv */
`timescale 1ns/1ns
`include "dma_init_defines.svh"

module dma_init_top (
  input  logic                  M_AXI_ACLK,
  input  logic                  M_AXI_ARESETN,
  input  dma_init_pkg::data_t   bus2ip_data,
  input  logic [`NUM_REGS-1:0]  bus2ip_rdce,
  input  logic [`NUM_REGS-1:0]  bus2ip_wrce,
  output dma_init_pkg::data_t   ip2bus_data,
  output logic                  ip2bus_rdack,
  output logic                  ip2bus_wrack,
  input  logic                  irq_dma,
  output dma_init_pkg::addr_t   m_axi_awaddr,
  output logic                  m_axi_awvalid,
  input  logic                  m_axi_awready,
  output dma_init_pkg::data_t   m_axi_wdata,
  output logic                  m_axi_wvalid,
  input  logic                  m_axi_wready,
  input  logic                  m_axi_bvalid,
  output logic                  m_axi_bready
);

  import dma_init_pkg::*;

  data_t        frame_len;
  data_t        buf_table_rd;
  data_t        cur_base;
  data_t        frame_cnt;
  data_t        frame_addr;
  buf_idx_t     buf_sel;
  logic         irq_pulse;
  cmd_idx_t     cmd_idx;
  axil_wr_cmd_t cmd;
  logic         cmd_valid;
  logic         wr_done;

  ////////////////////////////////////////////////////////////
  // Processor side
  ////////////////////////////////////////////////////////////

  up_reg_bank u_up_reg_bank (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .bus2ip_data   (bus2ip_data),
    .bus2ip_rdce   (bus2ip_rdce),
    .bus2ip_wrce   (bus2ip_wrce),
    .ip2bus_data   (ip2bus_data),
    .ip2bus_rdack  (ip2bus_rdack),
    .ip2bus_wrack  (ip2bus_wrack),
    .frame_len     (frame_len),
    .buf_sel       (buf_sel),
    .buf_table_rd  (buf_table_rd),
    .cur_base      (cur_base),
    .frame_cnt     (frame_cnt),
    .cmd_idx       (cmd_idx)
  );

  frame_tracker u_frame_tracker (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .irq_dma       (irq_dma),
    .frame_len     (frame_len),
    .buf_table_rd  (buf_table_rd),
    .buf_sel       (buf_sel),
    .cur_base      (cur_base),
    .frame_cnt     (frame_cnt),
    .frame_addr    (frame_addr),
    .irq_pulse     (irq_pulse)
  );

  ////////////////////////////////////////////////////////////
  // DMA programming side
  ////////////////////////////////////////////////////////////

  dma_cmd_seq u_dma_cmd_seq (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .frame_len     (frame_len),
    .cur_base      (cur_base),
    .frame_addr    (frame_addr),
    .irq_pulse     (irq_pulse),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .wr_done       (wr_done),
    .cmd_idx       (cmd_idx)
  );

  axil_write_master u_axil_write_master (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .cmd           (cmd),
    .cmd_valid     (cmd_valid),
    .wr_done       (wr_done),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready)
  );

endmodule

/* hw/dma_prog/axil_write_master.sv */
`timescale 1ns/1ns

module axil_write_master (
  input  logic                        M_AXI_ACLK,
  input  logic                        M_AXI_ARESETN,
  input  dma_init_pkg::axil_wr_cmd_t  cmd,
  input  logic                        cmd_valid,
  output logic                        wr_done,
  output dma_init_pkg::addr_t         m_axi_awaddr,
  output logic                        m_axi_awvalid,
  input  logic                        m_axi_awready,
  output dma_init_pkg::data_t         m_axi_wdata,
  output logic                        m_axi_wvalid,
  input  logic                        m_axi_wready,
  input  logic                        m_axi_bvalid,
  output logic                        m_axi_bready
);

  import dma_init_pkg::*;

  wr_state_t state;
  logic      aw_left;
  logic      w_left;

  // Channel still not accepted after this cycle
  assign aw_left = m_axi_awvalid & ~m_axi_awready;
  assign w_left  = m_axi_wvalid & ~m_axi_wready;

  assign m_axi_bready = (state == WR_RESP);

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      state         <= WR_IDLE;
      m_axi_awvalid <= 1'b0;
      m_axi_wvalid  <= 1'b0;
      wr_done       <= 1'b0;
    end
    else
    begin
      wr_done <= 1'b0;
      case (state)
        WR_IDLE:
          if (cmd_valid)
          begin
            m_axi_awvalid <= 1'b1;
            m_axi_wvalid  <= 1'b1;
            state         <= WR_ADDR_DATA;
          end
        WR_ADDR_DATA:
        begin
          // AW and W finish on their own
          if (m_axi_awready)
            m_axi_awvalid <= 1'b0;
          if (m_axi_wready)
            m_axi_wvalid <= 1'b0;
          if (!aw_left && !w_left)
            state <= WR_RESP;
        end
        WR_RESP:
          if (m_axi_bvalid)
          begin
            wr_done <= 1'b1;
            state   <= WR_IDLE;
          end
        default: state <= WR_IDLE;
      endcase
    end
  end

  // Command held stable until the next one is taken
  always_ff @(posedge M_AXI_ACLK)
  begin
    if ((state == WR_IDLE) && cmd_valid)
    begin
      m_axi_awaddr <= cmd.addr;
      m_axi_wdata  <= cmd.data;
    end
  end

endmodule

/* hw/dma_prog/dma_cmd_seq.sv */
`timescale 1ns/1ns
`include "dma_init_defines.svh"

module dma_cmd_seq (
  input  logic                        M_AXI_ACLK,
  input  logic                        M_AXI_ARESETN,
  input  dma_init_pkg::data_t         frame_len,
  input  dma_init_pkg::data_t         cur_base,
  input  dma_init_pkg::data_t         frame_addr,
  input  logic                        irq_pulse,
  output dma_init_pkg::axil_wr_cmd_t  cmd,
  output logic                        cmd_valid,
  input  logic                        wr_done,
  output dma_init_pkg::cmd_idx_t      cmd_idx
);

  import dma_init_pkg::*;

  seq_state_t   state;
  logic         irq_pend;
  logic         armed;
  cmd_idx_t     next_idx;
  axil_wr_cmd_t next_cmd;

  // Length must be nonzero and even, and a buffer must be present
  assign armed    = (frame_len != '0) && !frame_len[0] && (cur_base != '0);
  assign next_idx = cmd_idx + 1'b1;

  ////////////////////////////////////////////////////////////
  // Command table
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    next_cmd = '0;
    case (next_idx)
      3'd1: next_cmd = '{addr: `DMA_CTRL_ADDR, data: '0};
      3'd2: next_cmd = '{addr: `DMA_CFG0_ADDR, data: `DMA_CFG0_DATA};
      3'd3: next_cmd = '{addr: `DMA_CFG1_ADDR, data: `DMA_CFG1_DATA};
      3'd4: next_cmd = '{addr: `DMA_DEST_ADDR, data: frame_addr};
      3'd5: next_cmd = '{addr: `DMA_LEN_ADDR, data: `DMA_LEN_DATA};
      // Start bit plus length in 64-bit beats minus one
      3'd6: next_cmd = '{addr: `DMA_CTRL_ADDR,
                         data: (frame_len >> 1) - 1'b1 + `DMA_START_BIT};
      default: next_cmd = '0;
    endcase
  end

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (state == SEQ_ISSUE)
      cmd <= next_cmd;
  end

  ////////////////////////////////////////////////////////////
  // Sequencer FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      state     <= SEQ_IDLE;
      cmd_idx   <= '0;
      cmd_valid <= 1'b0;
      irq_pend  <= 1'b0;
    end
    else
    begin
      cmd_valid <= 1'b0;
      case (state)
        SEQ_IDLE:
          if (armed)
            state <= SEQ_ISSUE;
        SEQ_ISSUE:
        begin
          cmd_idx   <= next_idx;
          cmd_valid <= 1'b1;
          state     <= SEQ_WAIT;
        end
        SEQ_WAIT:
          if (wr_done)
            state <= (cmd_idx == `NUM_CMDS) ? SEQ_DONE : SEQ_ISSUE;
        SEQ_DONE:
          if (irq_pulse || irq_pend)
          begin
            cmd_idx  <= '0;
            irq_pend <= 1'b0;
            state    <= SEQ_IDLE;
          end
        default: state <= SEQ_IDLE;
      endcase
      // Interrupt mid-sequence waits for the current run to finish
      if (irq_pulse && ((state == SEQ_ISSUE) || (state == SEQ_WAIT)))
        irq_pend <= 1'b1;
    end
  end

endmodule

/* hw/frame_tracker.sv */
`timescale 1ns/1ns
`include "dma_init_defines.svh"

module frame_tracker #(
  parameter dma_init_pkg::data_t WINDOW_BYTES_P = `WINDOW_BYTES
) (
  input  logic                    M_AXI_ACLK,
  input  logic                    M_AXI_ARESETN,
  input  logic                    irq_dma,
  input  dma_init_pkg::data_t     frame_len,
  input  dma_init_pkg::data_t     buf_table_rd,
  output dma_init_pkg::buf_idx_t  buf_sel,
  output dma_init_pkg::data_t     cur_base,
  output dma_init_pkg::data_t     frame_cnt,
  output dma_init_pkg::data_t     frame_addr,
  output logic                    irq_pulse
);

  logic [1:0]           irq_sync;
  logic [2*`DATA_W-1:0] next_span;
  logic                 window_full;

  ////////////////////////////////////////////////////////////
  // Interrupt synchroniser and edge pulse
  ////////////////////////////////////////////////////////////

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      irq_sync  <= '0;
      irq_pulse <= 1'b0;
    end
    else
    begin
      irq_sync  <= {irq_sync[0], irq_dma};
      irq_pulse <= irq_sync[0] & ~irq_sync[1];
    end
  end

  // Bytes used once one more frame lands, kept wide against overflow
  assign next_span   = ({{`DATA_W{1'b0}}, frame_cnt} + 1'b1) *
                       {{(`DATA_W-2){1'b0}}, frame_len, 2'b00};
  assign window_full = (next_span >= WINDOW_BYTES_P);

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      frame_cnt <= '0;
      buf_sel   <= '0;
    end
    else if (irq_pulse)
    begin
      if (window_full)
      begin
        // Window used up, move on to the next buffer
        frame_cnt <= '0;
        buf_sel   <= buf_sel + 1'b1;
      end
      else
        frame_cnt <= frame_cnt + 1'b1;
    end
  end

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
      cur_base <= '0;
    else
      cur_base <= buf_table_rd;
  end

  // Destination of the current frame
  assign frame_addr = cur_base + (frame_len << 2) * frame_cnt;

endmodule

/* hw/reg_bank/up_reg_bank.sv */
`timescale 1ns/1ns
`include "dma_init_defines.svh"

module up_reg_bank (
  input  logic                    M_AXI_ACLK,
  input  logic                    M_AXI_ARESETN,
  input  dma_init_pkg::data_t     bus2ip_data,
  input  logic [`NUM_REGS-1:0]    bus2ip_rdce,
  input  logic [`NUM_REGS-1:0]    bus2ip_wrce,
  output dma_init_pkg::data_t     ip2bus_data,
  output logic                    ip2bus_rdack,
  output logic                    ip2bus_wrack,
  output dma_init_pkg::data_t     frame_len,
  input  dma_init_pkg::buf_idx_t  buf_sel,
  output dma_init_pkg::data_t     buf_table_rd,
  input  dma_init_pkg::data_t     cur_base,
  input  dma_init_pkg::data_t     frame_cnt,
  input  dma_init_pkg::cmd_idx_t  cmd_idx
);

  import dma_init_pkg::*;

  localparam int BUF_DEPTH = 2 ** `BUF_IDX_W;

  logic [`NUM_REGS-1:0] rwce;
  reg_idx_t             ce_idx;
  up_req_t              req;
  logic                 sel_d;
  logic                 sel_2d;
  logic                 ack;
  logic                 wr_en;
  data_t                rdata;
  data_t                buf_table [BUF_DEPTH];
  logic [BUF_DEPTH-1:0] buf_vld;
  buf_idx_t             wr_ptr;

  ////////////////////////////////////////////////////////////
  // Request capture and acknowledge
  ////////////////////////////////////////////////////////////

  assign rwce = bus2ip_rdce | bus2ip_wrce;

  // One-hot CE to register index
  always_comb
  begin
    ce_idx = '0;
    for (int i = 0; i < `NUM_REGS; i++)
    begin
      if (rwce[i])
        ce_idx = reg_idx_t'(`NUM_REGS - 1 - i);
    end
  end

  // Ack on the rising edge of the delayed select
  assign ack   = sel_d & ~sel_2d;
  // Only the first cycle of a held write
  assign wr_en = req.sel & ~req.rwn & ~sel_d;

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      req          <= '0;
      sel_d        <= 1'b0;
      sel_2d       <= 1'b0;
      ip2bus_rdack <= 1'b0;
      ip2bus_wrack <= 1'b0;
    end
    else
    begin
      req.sel      <= |rwce;
      req.rwn      <= |bus2ip_rdce;
      req.idx      <= ce_idx;
      req.wdata    <= bus2ip_data;
      sel_d        <= req.sel;
      sel_2d       <= sel_d;
      ip2bus_rdack <= ack & req.rwn;
      ip2bus_wrack <= ack & ~req.rwn;
    end
  end

  ////////////////////////////////////////////////////////////
  // Length register and buffer table
  ////////////////////////////////////////////////////////////

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      frame_len <= '0;
      wr_ptr    <= '0;
      buf_vld   <= '0;
    end
    else if (wr_en)
    begin
      if (req.idx == `REG_LEN)
        frame_len <= req.wdata;
      if (req.idx == `REG_BUF)
      begin
        buf_vld[wr_ptr] <= 1'b1;
        wr_ptr          <= wr_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge M_AXI_ACLK)
  begin
    if (wr_en && (req.idx == `REG_BUF))
      buf_table[wr_ptr] <= req.wdata;
  end

  // Unwritten entries read as zero so the sequencer stays idle
  assign buf_table_rd = buf_vld[buf_sel] ? buf_table[buf_sel] : '0;

  // Read-back mux, then the output stage that lines up with the ack
  always_ff @(posedge M_AXI_ACLK)
  begin
    case (req.idx)
      `REG_LEN:     rdata <= frame_len;
      `REG_BUF:     rdata <= cur_base;
      `REG_FRAMES:  rdata <= frame_cnt;
      `REG_CMD_IDX: rdata <= data_t'(cmd_idx);
      default:      rdata <= '0;
    endcase
    ip2bus_data <= rdata;
  end

endmodule

/* sources.f */
+incdir+common
+incdir+verif
common/dma_init_pkg.sv
hw/reg_bank/up_reg_bank.sv
hw/frame_tracker.sv
hw/dma_prog/dma_cmd_seq.sv
hw/dma_prog/axil_write_master.sv
hw/dma_init_top.sv
verif/tb_dma_init.sv

/* verif/tb_dma_init_tasks.svh */
////////////////////////////////////////////////////////////
// Checks and bus access
////////////////////////////////////////////////////////////

task automatic expect_value(input string name, input logic [31:0] got,
                            input logic [31:0] want);
  checks = checks + 1;
  if (got !== want)
  begin
    errors = errors + 1;
    $display("FAILED %s: expected 0x%08h, got 0x%08h", name, want, got);
  end
endtask

task automatic bus_write(input int idx, input logic [31:0] data);
  int n;
  n = 0;
  @(negedge M_AXI_ACLK);
  bus2ip_data = data;
  bus2ip_wrce = 32'h1 << (31 - idx);
  do
  begin
    @(negedge M_AXI_ACLK);
    n = n + 1;
  end while (!ip2bus_wrack && n < ACK_LIMIT);
  if (!ip2bus_wrack)
  begin
    errors = errors + 1;
    $display("ERROR: no write ack from register %0d within %0d cycles", idx, ACK_LIMIT);
  end
  bus2ip_wrce = '0;
  repeat (2) @(negedge M_AXI_ACLK);
endtask

task automatic bus_read(input int idx, output logic [31:0] data);
  int n;
  n = 0;
  data = 'x;
  @(negedge M_AXI_ACLK);
  bus2ip_rdce = 32'h1 << (31 - idx);
  do
  begin
    @(negedge M_AXI_ACLK);
    n = n + 1;
  end while (!ip2bus_rdack && n < ACK_LIMIT);
  if (ip2bus_rdack)
    data = ip2bus_data;
  else
  begin
    errors = errors + 1;
    $display("ERROR: no read ack from register %0d within %0d cycles", idx, ACK_LIMIT);
  end
  bus2ip_rdce = '0;
  repeat (2) @(negedge M_AXI_ACLK);
endtask

////////////////////////////////////////////////////////////
// Interrupts and the frame model
////////////////////////////////////////////////////////////

// Next frame position after one interrupt
task automatic advance_frame();
  longint span;
  span = longint'(exp_cnt + 1) * longint'(exp_len) * 4;
  if (span >= 64'h40_0000)
  begin
    exp_cnt = 0;
    exp_buf = (exp_buf + 1) % 32;
  end
  else
    exp_cnt = exp_cnt + 1;
endtask

function automatic logic [31:0] exp_dest();
  return bases[exp_buf] + exp_len * 4 * exp_cnt;
endfunction

task automatic pulse_irq();
  @(negedge M_AXI_ACLK);
  irq_dma = 1'b1;
  repeat (3) @(negedge M_AXI_ACLK);
  irq_dma = 1'b0;
  advance_frame();
endtask

task automatic wait_resp(input int target);
  int n;
  n = 0;
  while (resp_cnt < target && n < SEQ_LIMIT)
  begin
    @(negedge M_AXI_ACLK);
    n = n + 1;
  end
  if (resp_cnt < target)
  begin
    errors = errors + 1;
    $display("ERROR: only %0d of %0d AXI writes completed", resp_cnt, target);
  end
endtask

// Then stay quiet so that any extra write shows up
task automatic wait_writes(input int target);
  wait_resp(target);
  repeat (QUIET_CYCLES) @(negedge M_AXI_ACLK);
  expect_value("AXI write count", resp_cnt, target);
endtask

task automatic check_sequence(input int first, input logic [31:0] dest);
  logic [31:0] want_addr [6];
  logic [31:0] want_data [6];
  want_addr[0] = 32'h7900_000C;
  want_data[0] = 32'h0;
  want_addr[1] = 32'h4040_0030;
  want_data[1] = 32'h1001;
  want_addr[2] = 32'h4040_0034;
  want_data[2] = 32'h1000;
  want_addr[3] = 32'h4040_0048;
  want_data[3] = dest;
  want_addr[4] = 32'h4040_0058;
  want_data[4] = 32'hFFFF_FFFF;
  want_addr[5] = 32'h7900_000C;
  // Start bit plus 0x20000 beats minus one for a 0x40000 word frame
  want_data[5] = 32'h0002_FFFF;
  if (aw_log.size() < first + 6 || w_log.size() < first + 6)
  begin
    errors = errors + 1;
    $display("ERROR: fewer AXI writes logged than the sequence needs");
    return;
  end
  for (int k = 0; k < 6; k++)
  begin
    expect_value($sformatf("m_axi_awaddr of write %0d", first + k),
                 aw_log[first + k], want_addr[k]);
    expect_value($sformatf("m_axi_wdata of write %0d", first + k),
                 w_log[first + k], want_data[k]);
  end
endtask

////////////////////////////////////////////////////////////
// Directed tests
////////////////////////////////////////////////////////////

task automatic test_reset_readback();
  logic [31:0] rd;
  expect_value("m_axi_awvalid", m_axi_awvalid, 1'b0);
  expect_value("m_axi_wvalid", m_axi_wvalid, 1'b0);
  expect_value("m_axi_bready", m_axi_bready, 1'b0);
  expect_value("ip2bus_rdack", ip2bus_rdack, 1'b0);
  expect_value("ip2bus_wrack", ip2bus_wrack, 1'b0);
  bus_read(IDX_FRAMES, rd);
  expect_value("REG_FRAMES", rd, 32'h0);
  bus_read(IDX_CMD_IDX, rd);
  expect_value("REG_CMD_IDX", rd, 32'h0);
  bus_write(IDX_LEN, 32'h0000_1234);
  exp_len = 32'h0000_1234;
  bus_read(IDX_LEN, rd);
  expect_value("REG_LEN", rd, 32'h0000_1234);
  bus_read(9, rd);
  expect_value("unused register 9", rd, 32'h0);
  expect_value("AXI address count", aw_log.size(), 0);
endtask

task automatic test_arming();
  logic [31:0] rd;
  // Even length but no buffer yet
  bus_write(IDX_LEN, 32'h0004_0000);
  repeat (QUIET_CYCLES) @(negedge M_AXI_ACLK);
  expect_value("AXI address count", aw_log.size(), 0);
  // Buffer present but odd length
  bus_write(IDX_LEN, 32'h0004_0001);
  bus_write(IDX_BUF, 32'h1000_0000);
  bases.push_back(32'h1000_0000);
  repeat (QUIET_CYCLES) @(negedge M_AXI_ACLK);
  expect_value("AXI address count", aw_log.size(), 0);
  bus_write(IDX_LEN, 32'h0004_0000);
  exp_len    = 32'h0004_0000;
  writes_exp = writes_exp + 6;
  wait_writes(writes_exp);
  check_sequence(writes_exp - 6, exp_dest());
  bus_read(IDX_CMD_IDX, rd);
  expect_value("REG_CMD_IDX", rd, 32'd6);
endtask

task automatic test_irq_restart();
  logic [31:0] rd;
  pulse_irq();
  writes_exp = writes_exp + 6;
  wait_writes(writes_exp);
  check_sequence(writes_exp - 6, exp_dest());
  bus_read(IDX_FRAMES, rd);
  expect_value("REG_FRAMES", rd, exp_cnt);
endtask

task automatic test_window_wrap();
  logic [31:0] rd;
  bus_write(IDX_BUF, 32'h2000_0000);
  bases.push_back(32'h2000_0000);
  // Interrupts two to four, where the fourth fills the window
  for (int i = 0; i < 3; i++)
  begin
    pulse_irq();
    writes_exp = writes_exp + 6;
    wait_writes(writes_exp);
    check_sequence(writes_exp - 6, exp_dest());
  end
  bus_read(IDX_FRAMES, rd);
  expect_value("REG_FRAMES", rd, exp_cnt);
  bus_read(IDX_BUF, rd);
  expect_value("REG_BUF", rd, 32'h2000_0000);
endtask

task automatic test_back_pressure();
  logic [31:0] rd;
  logic [31:0] first_dest;
  logic [31:0] second_dest;
  max_delay = 1'b1;
  pulse_irq();
  first_dest = exp_dest();
  // Second interrupt lands while command 5 is in flight
  wait_resp(writes_exp + 4);
  pulse_irq();
  second_dest = exp_dest();
  writes_exp  = writes_exp + 12;
  wait_writes(writes_exp);
  check_sequence(writes_exp - 12, first_dest);
  check_sequence(writes_exp - 6, second_dest);
  bus_read(IDX_FRAMES, rd);
  expect_value("REG_FRAMES", rd, exp_cnt);
  max_delay = 1'b0;
endtask

/* verif/tb_dma_init.sv */
`timescale 1ns/1ns

module tb_dma_init;

  // Register indices as seen by the processor
  localparam int IDX_LEN     = 0;
  localparam int IDX_BUF     = 1;
  localparam int IDX_FRAMES  = 2;
  localparam int IDX_CMD_IDX = 3;

  localparam int ACK_LIMIT    = 16;
  localparam int SEQ_LIMIT    = 1000;
  localparam int QUIET_CYCLES = 20;
  // Tests need about 2000 cycles, so this leaves a wide margin
  localparam int TIMEOUT_CYCLES = 20000;

  logic        M_AXI_ACLK;
  logic        M_AXI_ARESETN;
  logic [31:0] bus2ip_data;
  logic [31:0] bus2ip_rdce;
  logic [31:0] bus2ip_wrce;
  logic [31:0] ip2bus_data;
  logic        ip2bus_rdack;
  logic        ip2bus_wrack;
  logic        irq_dma;
  logic [31:0] m_axi_awaddr;
  logic        m_axi_awvalid;
  logic        m_axi_awready;
  logic [31:0] m_axi_wdata;
  logic        m_axi_wvalid;
  logic        m_axi_wready;
  logic        m_axi_bvalid;
  logic        m_axi_bready;

  int          errors = 0;
  int          checks = 0;
  int          cycle_cnt = 0;
  int          seed = 32'hc4d1;
  logic        max_delay = 1'b0;

  // Slave model state and write log
  int          aw_wait = -1;
  int          w_wait = -1;
  logic [31:0] aw_hold;
  logic [31:0] w_hold;
  logic [31:0] aw_log [$];
  logic [31:0] w_log [$];
  int          resp_cnt = 0;

  // Reference model of the frame position
  logic [31:0] exp_len = '0;
  int          exp_cnt = 0;
  int          exp_buf = 0;
  logic [31:0] bases [$];
  int          writes_exp = 0;

  dma_init_top u_dma_init_top (
    .M_AXI_ACLK    (M_AXI_ACLK),
    .M_AXI_ARESETN (M_AXI_ARESETN),
    .bus2ip_data   (bus2ip_data),
    .bus2ip_rdce   (bus2ip_rdce),
    .bus2ip_wrce   (bus2ip_wrce),
    .ip2bus_data   (ip2bus_data),
    .ip2bus_rdack  (ip2bus_rdack),
    .ip2bus_wrack  (ip2bus_wrack),
    .irq_dma       (irq_dma),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awready (m_axi_awready),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wready  (m_axi_wready),
    .m_axi_bvalid  (m_axi_bvalid),
    .m_axi_bready  (m_axi_bready)
  );

  `include "tb_dma_init_tasks.svh"

  initial
  begin
    M_AXI_ACLK = 1'b0;
    forever #4 M_AXI_ACLK = ~M_AXI_ACLK;
  end

  ////////////////////////////////////////////////////////////
  // AXI4-Lite slave model
  ////////////////////////////////////////////////////////////

  function automatic int pick_delay();
    if (max_delay)
      return 3;
    return $unsigned($random(seed)) % 4;
  endfunction

  // Handshakes are taken where the DUT sees them
  always @(posedge M_AXI_ACLK)
  begin
    if (M_AXI_ARESETN)
    begin
      if (m_axi_awvalid && m_axi_awready)
        aw_log.push_back(m_axi_awaddr);
      if (m_axi_wvalid && m_axi_wready)
        w_log.push_back(m_axi_wdata);
      if (m_axi_bvalid && m_axi_bready)
        resp_cnt = resp_cnt + 1;
    end
  end

  always @(negedge M_AXI_ACLK)
  begin
    if (!M_AXI_ARESETN)
    begin
      m_axi_awready = 1'b0;
      m_axi_wready  = 1'b0;
      m_axi_bvalid  = 1'b0;
      aw_wait       = -1;
      w_wait        = -1;
    end
    else
    begin
      // Address channel
      if (m_axi_awready)
      begin
        m_axi_awready = 1'b0;
        aw_wait       = -1;
      end
      else if (m_axi_awvalid)
      begin
        if (aw_wait < 0)
        begin
          aw_wait = pick_delay();
          aw_hold = m_axi_awaddr;
        end
        else if (m_axi_awaddr !== aw_hold)
        begin
          errors = errors + 1;
          $display("FAILED m_axi_awaddr changed while waiting: 0x%08h to 0x%08h",
                   aw_hold, m_axi_awaddr);
        end
        if (aw_wait == 0)
          m_axi_awready = 1'b1;
        else
          aw_wait = aw_wait - 1;
      end
      // Data channel
      if (m_axi_wready)
      begin
        m_axi_wready = 1'b0;
        w_wait       = -1;
      end
      else if (m_axi_wvalid)
      begin
        if (w_wait < 0)
        begin
          w_wait = pick_delay();
          w_hold = m_axi_wdata;
        end
        else if (m_axi_wdata !== w_hold)
        begin
          errors = errors + 1;
          $display("FAILED m_axi_wdata changed while waiting: 0x%08h to 0x%08h",
                   w_hold, m_axi_wdata);
        end
        if (w_wait == 0)
          m_axi_wready = 1'b1;
        else
          w_wait = w_wait - 1;
      end
      // Response one cycle after both channels are taken
      if (m_axi_bvalid)
        m_axi_bvalid = 1'b0;
      else if (m_axi_bready)
        m_axi_bvalid = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////////////////////////

  always @(posedge M_AXI_ACLK)
    cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("ERROR: run stopped by the timeout after %0d cycles", cycle_cnt);
    $display("Checks run: %0d, errors: %0d", checks, errors + 1);
    $display("*** TEST FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial
  begin
    M_AXI_ARESETN = 1'b0;
    bus2ip_data   = '0;
    bus2ip_rdce   = '0;
    bus2ip_wrce   = '0;
    irq_dma       = 1'b0;
    m_axi_awready = 1'b0;
    m_axi_wready  = 1'b0;
    m_axi_bvalid  = 1'b0;
    repeat (4) @(negedge M_AXI_ACLK);
    M_AXI_ARESETN = 1'b1;
    repeat (2) @(negedge M_AXI_ACLK);

    test_reset_readback();
    test_arming();
    test_irq_restart();
    test_window_wrap();
    test_back_pressure();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
